// File: project.f
fc_l2_pkg.sv
fc_addr_decode.sv
fc_target_arbiter.sv
l2_bank.sv
fc_ext_port.sv
fc_resp_route.sv
fc_interconnect.sv
tb_fc_interconnect.sv

// File: Bender.yml
package:
  name: fc_interconnect

sources:
  - fc_l2_pkg.sv
  - fc_addr_decode.sv
  - fc_target_arbiter.sv
  - l2_bank.sv
  - fc_ext_port.sv
  - fc_resp_route.sv
  - fc_interconnect.sv
  - target: simulation
    files:
      - tb_fc_interconnect.sv

// File: tb_fc_interconnect.sv
// Testbench for the FC memory interconnect
// Applies a table of grouped master accesses; accesses in one group run
// concurrently on their masters. A bridge model answers external requests
// after a random delay and hands back one credit per answer.

module tb_fc_interconnect;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_MASTERS   = 3;
   localparam int EXT_CREDITS = 2;
   localparam int IDX_W       = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;
   localparam int CLK_PERIOD  = 20;
   localparam int RST_CYCLES  = 10;

   typedef struct {
      int                  grp;
      int                  master;
      logic                wen;
      fc_l2_pkg::addr_t    addr;
      fc_l2_pkg::data_t    wdata;
      fc_l2_pkg::be_t      be;
      fc_l2_pkg::data_t    exp_rdata;
      logic                exp_opc;
   } entry_t;

   typedef struct {
      fc_l2_pkg::addr_t    addr;
      logic                wen;
      fc_l2_pkg::data_t    wdata;
      fc_l2_pkg::be_t      be;
      logic [IDX_W-1:0]    id;
      int                  due;
   } ext_txn_t;

   logic                             clk;
   logic                             rst_n;
   logic [N_MASTERS-1:0]             req;
   fc_l2_pkg::addr_t [N_MASTERS-1:0] addr;
   logic [N_MASTERS-1:0]             wen;
   fc_l2_pkg::data_t [N_MASTERS-1:0] wdata;
   fc_l2_pkg::be_t [N_MASTERS-1:0]   be;
   logic [N_MASTERS-1:0]             gnt;
   logic [N_MASTERS-1:0]             r_valid;
   fc_l2_pkg::data_t [N_MASTERS-1:0] r_rdata;
   logic [N_MASTERS-1:0]             r_opc;
   logic                             ext_req;
   fc_l2_pkg::addr_t                 ext_addr;
   logic                             ext_wen;
   fc_l2_pkg::data_t                 ext_wdata;
   fc_l2_pkg::be_t                   ext_be;
   logic [IDX_W-1:0]                 ext_id;
   logic                             ext_credit;
   logic                             ext_r_valid;
   logic [IDX_W-1:0]                 ext_r_id;
   fc_l2_pkg::data_t                 ext_r_rdata;
   logic                             ext_r_opc;

   entry_t           tbl[$];
   ext_txn_t         pend[$];
   fc_l2_pkg::data_t ext_mem [16];
   int               n_groups;
   int               cyc;
   int               outstanding;
   logic             credit_pend;
   logic             table_ready;
   integer           seed = 58856;

   fc_interconnect fc_interconnect_i
   (
      .clk_i         ( clk         ),
      .rst_n_i       ( rst_n       ),
      .req_i         ( req         ),
      .addr_i        ( addr        ),
      .wen_i         ( wen         ),
      .wdata_i       ( wdata       ),
      .be_i          ( be          ),
      .gnt_o         ( gnt         ),
      .r_valid_o     ( r_valid     ),
      .r_rdata_o     ( r_rdata     ),
      .r_opc_o       ( r_opc       ),
      .ext_req_o     ( ext_req     ),
      .ext_addr_o    ( ext_addr    ),
      .ext_wen_o     ( ext_wen     ),
      .ext_wdata_o   ( ext_wdata   ),
      .ext_be_o      ( ext_be      ),
      .ext_id_o      ( ext_id      ),
      .ext_credit_i  ( ext_credit  ),
      .ext_r_valid_i ( ext_r_valid ),
      .ext_r_id_i    ( ext_r_id    ),
      .ext_r_rdata_i ( ext_r_rdata ),
      .ext_r_opc_i   ( ext_r_opc   )
   );

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped on first failure");
   endtask

   task automatic check_data(input string sig, input fc_l2_pkg::data_t got,
                             input fc_l2_pkg::data_t exp);
      if (got !== exp)
      begin
         fail_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, sig, got, exp));
      end
   endtask

   task automatic check_opc(input string sig, input logic got, input logic exp);
      if (got !== exp)
      begin
         fail_run($sformatf("Error at %0d ns: %s is %b, expected %b", $time, sig, got, exp));
      end
   endtask

   // A byte-enabled write leaves the disabled bytes alone
   function automatic fc_l2_pkg::data_t merge_bytes(input fc_l2_pkg::data_t old_w,
                                                    input fc_l2_pkg::data_t new_w,
                                                    input fc_l2_pkg::be_t be_w);
      fc_l2_pkg::data_t res;
      res = old_w;
      for (int i = 0; i < 4; i++)
      begin
         if (be_w[i])
         begin
            res[8*i +: 8] = new_w[8*i +: 8];
         end
      end
      return res;
   endfunction

   function automatic logic in_l2_window(input fc_l2_pkg::addr_t a);
      fc_l2_pkg::addr_t top;
      top = fc_l2_pkg::L2_BASE + (fc_l2_pkg::addr_t'(1) << fc_l2_pkg::L2_SPAN_LOG2);
      return (a >= fc_l2_pkg::L2_BASE) && (a < top);
   endfunction

   task automatic add_entry(input int g, input int m, input logic w, input fc_l2_pkg::addr_t a,
                            input fc_l2_pkg::data_t d, input fc_l2_pkg::be_t b,
                            input fc_l2_pkg::data_t exp_d, input logic exp_o);
      entry_t e;
      e = '{grp: g, master: m, wen: w, addr: a, wdata: d, be: b,
            exp_rdata: exp_d, exp_opc: exp_o};
      tbl.push_back(e);
      if (g + 1 > n_groups)
      begin
         n_groups = g + 1;
      end
   endtask

   // ------------------------------------------------------------
   // Stimulus table
   // ------------------------------------------------------------
   task automatic build_table();
      logic ok;
      logic err;
      ok  = fc_l2_pkg::OPC_OK;
      err = fc_l2_pkg::OPC_ERR;
      n_groups = 0;
      // L2 read-back, then a byte merge into the same word
      add_entry(0, 0, 1, 32'h1C00_0000, 32'hDEAD_BEEF, 4'hF, '0, ok);
      add_entry(1, 0, 0, 32'h1C00_0000, '0, 4'hF, 32'hDEAD_BEEF, ok);
      add_entry(2, 1, 1, 32'h1C00_0000, 32'h1200_5A00, 4'b1010, '0, ok);
      add_entry(3, 2, 0, 32'h1C00_0000, '0, 4'hF,
                merge_bytes(32'hDEAD_BEEF, 32'h1200_5A00, 4'b1010), ok);
      // Consecutive words land in consecutive banks
      add_entry(4, 0, 1, 32'h1C00_0010, 32'h1111_1111, 4'hF, '0, ok);
      add_entry(4, 1, 1, 32'h1C00_0014, 32'h2222_2222, 4'hF, '0, ok);
      add_entry(4, 2, 1, 32'h1C00_0018, 32'h3333_3333, 4'hF, '0, ok);
      add_entry(5, 0, 0, 32'h1C00_0014, '0, 4'hF, 32'h2222_2222, ok);
      add_entry(5, 1, 0, 32'h1C00_0018, '0, 4'hF, 32'h3333_3333, ok);
      add_entry(5, 2, 0, 32'h1C00_0010, '0, 4'hF, 32'h1111_1111, ok);
      // Two masters on bank 0
      add_entry(6, 0, 1, 32'h1C00_0020, 32'hA5A5_0001, 4'hF, '0, ok);
      add_entry(6, 1, 1, 32'h1C00_0030, 32'hA5A5_0002, 4'hF, '0, ok);
      add_entry(7, 1, 0, 32'h1C00_0020, '0, 4'hF, 32'hA5A5_0001, ok);
      add_entry(7, 2, 0, 32'h1C00_0030, '0, 4'hF, 32'hA5A5_0002, ok);
      // Inside the L2 window but past the banks
      add_entry(8, 0, 0, 32'h1C00_2000, '0, 4'hF, '0, err);
      add_entry(8, 1, 1, 32'h1C00_FFFC, 32'h0BAD_0BAD, 4'hF, '0, err);
      // Bridge traffic with more requests than credits
      add_entry(9, 0, 1, 32'h4000_0004, 32'hCAFE_0001, 4'hF, '0, ok);
      add_entry(9, 1, 1, 32'h4000_0008, 32'hCAFE_0002, 4'hF, '0, ok);
      add_entry(9, 2, 1, 32'h4000_000C, 32'hCAFE_0003, 4'hF, '0, ok);
      add_entry(10, 2, 0, 32'h4000_0004, '0, 4'hF, 32'hCAFE_0001, ok);
      add_entry(10, 0, 0, 32'h4000_0008, '0, 4'hF, 32'hCAFE_0002, ok);
      add_entry(10, 1, 0, 32'h4000_000C, '0, 4'hF, 32'hCAFE_0003, ok);
      add_entry(11, 1, 0, 32'hF000_0000, '0, 4'hF, '0, err);
      add_entry(11, 0, 0, 32'h1C00_0014, '0, 4'hF, 32'h2222_2222, ok);
   endtask

   // ------------------------------------------------------------
   // Master side
   // ------------------------------------------------------------
   task automatic do_access(input int i);
      int     m;
      int     lat;
      entry_t e;
      e = tbl[i];
      m = e.master;
      @(posedge clk);
      #2;
      req[m]   = 1'b1;
      addr[m]  = e.addr;
      wen[m]   = e.wen;
      wdata[m] = e.wdata;
      be[m]    = e.be;
      @(negedge clk);
      while (!gnt[m])
      begin
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      req[m] = 1'b0;
      lat = 1;
      @(negedge clk);
      while (!r_valid[m])
      begin
         @(negedge clk);
         lat++;
      end
      if (in_l2_window(e.addr) && lat != 1)
      begin
         fail_run($sformatf("Master %0d got an L2 response %0d cycles after its grant", m, lat));
      end
      check_opc($sformatf("r_opc_o[%0d]", m), r_opc[m], e.exp_opc);
      if (!e.wen)
      begin
         check_data($sformatf("r_rdata_o[%0d]", m), r_rdata[m], e.exp_rdata);
      end
   endtask

   task automatic run_master(input int m, input int g);
      for (int i = 0; i < tbl.size(); i++)
      begin
         if (tbl[i].grp == g && tbl[i].master == m)
         begin
            do_access(i);
         end
      end
   endtask

   // ------------------------------------------------------------
   // Bridge model
   // ------------------------------------------------------------
   // Sample outbound requests and count credits in flight
   always @(negedge clk)
   begin : bridge_sample
      ext_txn_t t;
      if (rst_n)
      begin
         if (ext_credit)
         begin
            outstanding--;
         end
         if (ext_req)
         begin
            t = '{addr: ext_addr, wen: ext_wen, wdata: ext_wdata, be: ext_be, id: ext_id,
                  due: cyc + 1 + ($unsigned($random(seed)) % 6)};
            pend.push_back(t);
            outstanding++;
         end
         if (outstanding > EXT_CREDITS)
         begin
            fail_run($sformatf("Bridge holds %0d requests, more than its %0d credits",
                               outstanding, EXT_CREDITS));
         end
      end
   end

   initial
   begin : bridge_drive
      ext_txn_t t;
      ext_credit  = 1'b0;
      ext_r_valid = 1'b0;
      ext_r_id    = '0;
      ext_r_rdata = '0;
      ext_r_opc   = 1'b0;
      credit_pend = 1'b0;
      cyc         = 0;
      outstanding = 0;
      for (int i = 0; i < 16; i++)
      begin
         ext_mem[i] = 32'hE000_0000 | (i * 32'h0001_0203);
      end
      forever
      begin
         @(posedge clk);
         #2;
         cyc++;
         ext_credit  = credit_pend;
         credit_pend = 1'b0;
         ext_r_valid = 1'b0;
         ext_r_rdata = '0;
         if (pend.size() > 0 && cyc >= pend[0].due)
         begin
            t = pend.pop_front();
            ext_r_valid = 1'b1;
            ext_r_id    = t.id;
            // Top nibble F is an unmapped region on the bridge
            if (t.addr[31:28] == 4'hF)
            begin
               ext_r_opc = fc_l2_pkg::OPC_ERR;
            end
            else
            begin
               ext_r_opc = fc_l2_pkg::OPC_OK;
               if (t.wen)
               begin
                  ext_mem[t.addr[5:2]] = merge_bytes(ext_mem[t.addr[5:2]], t.wdata, t.be);
               end
               else
               begin
                  ext_r_rdata = ext_mem[t.addr[5:2]];
               end
            end
            credit_pend = 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // Clock, watchdog and main sequence
   // ------------------------------------------------------------
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   initial
   begin : watchdog
      wait (table_ready === 1'b1);
      #((RST_CYCLES + tbl.size() * 20) * CLK_PERIOD);
      fail_run("Timeout, the table did not complete in time");
   end

   initial
   begin
      table_ready = 1'b0;
      rst_n = 1'b0;
      req   = '0;
      addr  = '0;
      wen   = '0;
      wdata = '0;
      be    = '0;
      build_table();
      table_ready = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;

      for (int g = 0; g < n_groups; g++)
      begin
         for (int m = 0; m < N_MASTERS; m++)
         begin
            fork
               automatic int mm = m;
               run_master(mm, g);
            join_none
         end
         wait fork;
      end

      // Let the last credits come home
      repeat (4) @(posedge clk);
      if (pend.size() == 0 && outstanding == 0)
      begin
         $display("*** TEST PASSED ***");
         $finish;
      end
      else
      begin
         fail_run("Bridge requests or credits still outstanding at the end");
      end
   end

endmodule

// File: fc_interconnect.sv
// FC memory interconnect top level
// Masters reach word-interleaved L2 banks or the external bridge port;
// L2 answers one cycle after the grant, the bridge after a variable delay

module fc_interconnect
#(
   parameter  int N_MASTERS       = 3,
   parameter  int N_L2_BANKS      = 4,
   parameter  int BANK_ADDR_WIDTH = 8,
   parameter  int EXT_CREDITS     = 2,
   localparam int IDX_W           = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1
)
(
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   // Master side
   input  logic [N_MASTERS-1:0]             req_i,
   input  fc_l2_pkg::addr_t [N_MASTERS-1:0] addr_i,
   input  logic [N_MASTERS-1:0]             wen_i,
   input  fc_l2_pkg::data_t [N_MASTERS-1:0] wdata_i,
   input  fc_l2_pkg::be_t [N_MASTERS-1:0]   be_i,
   output logic [N_MASTERS-1:0]             gnt_o,
   output logic [N_MASTERS-1:0]             r_valid_o,
   output fc_l2_pkg::data_t [N_MASTERS-1:0] r_rdata_o,
   output logic [N_MASTERS-1:0]             r_opc_o,
   // Bridge side
   output logic                             ext_req_o,
   output fc_l2_pkg::addr_t                 ext_addr_o,
   output logic                             ext_wen_o,
   output fc_l2_pkg::data_t                 ext_wdata_o,
   output fc_l2_pkg::be_t                   ext_be_o,
   output logic [IDX_W-1:0]                 ext_id_o,
   input  logic                             ext_credit_i,
   input  logic                             ext_r_valid_i,
   input  logic [IDX_W-1:0]                 ext_r_id_i,
   input  fc_l2_pkg::data_t                 ext_r_rdata_i,
   input  logic                             ext_r_opc_i
);

   // Row bits sit right above the bank select bits
   localparam int ROW_LSB = fc_l2_pkg::WORD_OFFSET + $clog2(N_L2_BANKS);

   logic [N_L2_BANKS-1:0][N_MASTERS-1:0] bank_req;
   logic [N_L2_BANKS-1:0][N_MASTERS-1:0] bank_gnt;
   logic [N_L2_BANKS-1:0][IDX_W-1:0]     bank_idx;
   logic [N_L2_BANKS-1:0]                bank_hit;
   fc_l2_pkg::data_t [N_L2_BANKS-1:0]    bank_rdata;
   logic [N_MASTERS-1:0]                 ext_req;
   logic [N_MASTERS-1:0]                 ext_gnt;
   logic [N_MASTERS-1:0]                 err_req;
   logic [IDX_W-1:0]                     ext_idx;
   logic                                 credit_ok;

   // ------------------------------------------------------------
   // Decode
   // ------------------------------------------------------------
   fc_addr_decode
   #(
      .N_MASTERS       ( N_MASTERS       ),
      .N_L2_BANKS      ( N_L2_BANKS      ),
      .BANK_ADDR_WIDTH ( BANK_ADDR_WIDTH )
   )
   i_decode
   (
      .clk_i      ( clk_i     ),
      .rst_n_i    ( rst_n_i   ),
      .req_i      ( req_i     ),
      .addr_i     ( addr_i    ),
      .rsp_done_i ( r_valid_o ),
      .bank_req_o ( bank_req  ),
      .ext_req_o  ( ext_req   ),
      .err_req_o  ( err_req   ),
      .gnt_i      ( gnt_o     )
   );

   // ------------------------------------------------------------
   // Execute: per-bank arbitration and access
   // ------------------------------------------------------------
   for (genvar b = 0; b < N_L2_BANKS; b++)
   begin : gen_bank
      fc_target_arbiter #( .N_MASTERS ( N_MASTERS ) ) i_bank_arb
      (
         .clk_i     ( clk_i       ),
         .rst_n_i   ( rst_n_i     ),
         .req_i     ( bank_req[b] ),
         .enable_i  ( 1'b1        ),
         .gnt_o     ( bank_gnt[b] ),
         .gnt_idx_o ( bank_idx[b] )
      );

      assign bank_hit[b] = |bank_gnt[b];

      l2_bank #( .BANK_ADDR_WIDTH ( BANK_ADDR_WIDTH ) ) i_l2_bank
      (
         .clk_i   ( clk_i                                               ),
         .csn_i   ( ~bank_hit[b]                                        ),
         .wen_i   ( wen_i[bank_idx[b]]                                  ),
         .row_i   ( addr_i[bank_idx[b]][ROW_LSB +: BANK_ADDR_WIDTH]     ),
         .wdata_i ( wdata_i[bank_idx[b]]                                ),
         .be_i    ( be_i[bank_idx[b]]                                   ),
         .rdata_o ( bank_rdata[b]                                       )
      );
   end

   // ------------------------------------------------------------
   // Execute: bridge arbitration and port
   // ------------------------------------------------------------
   fc_target_arbiter #( .N_MASTERS ( N_MASTERS ) ) i_ext_arb
   (
      .clk_i     ( clk_i     ),
      .rst_n_i   ( rst_n_i   ),
      .req_i     ( ext_req   ),
      .enable_i  ( credit_ok ),
      .gnt_o     ( ext_gnt   ),
      .gnt_idx_o ( ext_idx   )
   );

   fc_ext_port
   #(
      .N_MASTERS   ( N_MASTERS   ),
      .EXT_CREDITS ( EXT_CREDITS )
   )
   i_ext_port
   (
      .clk_i        ( clk_i            ),
      .rst_n_i      ( rst_n_i          ),
      .grant_i      ( |ext_gnt         ),
      .gnt_idx_i    ( ext_idx          ),
      .addr_i       ( addr_i[ext_idx]  ),
      .wen_i        ( wen_i[ext_idx]   ),
      .wdata_i      ( wdata_i[ext_idx] ),
      .be_i         ( be_i[ext_idx]    ),
      .credit_ok_o  ( credit_ok        ),
      .ext_credit_i ( ext_credit_i     ),
      .ext_req_o    ( ext_req_o        ),
      .ext_addr_o   ( ext_addr_o       ),
      .ext_wen_o    ( ext_wen_o        ),
      .ext_wdata_o  ( ext_wdata_o      ),
      .ext_be_o     ( ext_be_o         ),
      .ext_id_o     ( ext_id_o         )
   );

   // Out-of-range L2 requests are granted at once
   always_comb
   begin
      gnt_o = ext_gnt | err_req;
      for (int b = 0; b < N_L2_BANKS; b++)
      begin
         gnt_o = gnt_o | bank_gnt[b];
      end
   end

   // ------------------------------------------------------------
   // Result
   // ------------------------------------------------------------
   fc_resp_route
   #(
      .N_MASTERS  ( N_MASTERS  ),
      .N_L2_BANKS ( N_L2_BANKS )
   )
   i_resp_route
   (
      .clk_i         ( clk_i         ),
      .rst_n_i       ( rst_n_i       ),
      .bank_gnt_i    ( bank_hit      ),
      .bank_idx_i    ( bank_idx      ),
      .bank_rdata_i  ( bank_rdata    ),
      .err_gnt_i     ( err_req       ),
      .ext_r_valid_i ( ext_r_valid_i ),
      .ext_r_id_i    ( ext_r_id_i    ),
      .ext_r_rdata_i ( ext_r_rdata_i ),
      .ext_r_opc_i   ( ext_r_opc_i   ),
      .r_valid_o     ( r_valid_o     ),
      .r_rdata_o     ( r_rdata_o     ),
      .r_opc_o       ( r_opc_o       )
   );

endmodule

// File: fc_resp_route.sv
// Result stage of the interconnect
// Steers bank read data and out-of-range errors back one cycle after the
// grant, and passes bridge responses straight to the master in ext_r_id_i

module fc_resp_route
#(
   parameter  int N_MASTERS  = 3,
   parameter  int N_L2_BANKS = 4,
   localparam int IDX_W      = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1
)
(
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic [N_L2_BANKS-1:0]             bank_gnt_i,
   input  logic [N_L2_BANKS-1:0][IDX_W-1:0]  bank_idx_i,
   input  fc_l2_pkg::data_t [N_L2_BANKS-1:0] bank_rdata_i,
   input  logic [N_MASTERS-1:0]              err_gnt_i,
   input  logic                              ext_r_valid_i,
   input  logic [IDX_W-1:0]                  ext_r_id_i,
   input  fc_l2_pkg::data_t                  ext_r_rdata_i,
   input  logic                              ext_r_opc_i,
   output logic [N_MASTERS-1:0]              r_valid_o,
   output fc_l2_pkg::data_t [N_MASTERS-1:0]  r_rdata_o,
   output logic [N_MASTERS-1:0]              r_opc_o
);

   logic [N_L2_BANKS-1:0]            bank_vld_q;
   logic [N_L2_BANKS-1:0][IDX_W-1:0] bank_idx_q;
   logic [N_MASTERS-1:0]             err_q;

   // ------------------------------------------------------------
   // Who was served last cycle
   // ------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         bank_vld_q <= '0;
         err_q      <= '0;
      end
      else
      begin
         bank_vld_q <= bank_gnt_i;
         err_q      <= err_gnt_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      bank_idx_q <= bank_idx_i;
   end

   // ------------------------------------------------------------
   // Response steering
   // ------------------------------------------------------------
   // A master has one transaction in flight, so at most one source hits it
   always_comb
   begin
      for (int m = 0; m < N_MASTERS; m++)
      begin
         r_valid_o[m] = 1'b0;
         r_rdata_o[m] = '0;
         r_opc_o[m]   = fc_l2_pkg::OPC_OK;

         for (int b = 0; b < N_L2_BANKS; b++)
         begin
            if (bank_vld_q[b] && (bank_idx_q[b] == IDX_W'(m)))
            begin
               r_valid_o[m] = 1'b1;
               r_rdata_o[m] = bank_rdata_i[b];
            end
         end

         if (err_q[m])
         begin
            r_valid_o[m] = 1'b1;
            r_opc_o[m]   = fc_l2_pkg::OPC_ERR;
         end

         if (ext_r_valid_i && (ext_r_id_i == IDX_W'(m)))
         begin
            r_valid_o[m] = 1'b1;
            r_rdata_o[m] = ext_r_rdata_i;
            r_opc_o[m]   = ext_r_opc_i;
         end
      end
   end

endmodule

// File: fc_ext_port.sv
// External bridge port
// Tracks bridge credits and registers one outbound request per grant,
// so ext_req_o follows the grant by one cycle

module fc_ext_port
#(
   parameter  int N_MASTERS   = 3,
   parameter  int EXT_CREDITS = 2,
   localparam int IDX_W       = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1,
   localparam int CNT_W       = $clog2(EXT_CREDITS + 1)
)
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    grant_i,
   input  logic [IDX_W-1:0]        gnt_idx_i,
   input  fc_l2_pkg::addr_t        addr_i,
   input  logic                    wen_i,
   input  fc_l2_pkg::data_t        wdata_i,
   input  fc_l2_pkg::be_t          be_i,
   output logic                    credit_ok_o,
   input  logic                    ext_credit_i,
   output logic                    ext_req_o,
   output fc_l2_pkg::addr_t        ext_addr_o,
   output logic                    ext_wen_o,
   output fc_l2_pkg::data_t        ext_wdata_o,
   output fc_l2_pkg::be_t          ext_be_o,
   output logic [IDX_W-1:0]        ext_id_o
);

   logic [CNT_W-1:0] credit_q;

   // Credit is taken at grant time so back-to-back grants cannot overrun
   assign credit_ok_o = (credit_q != '0);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         credit_q  <= CNT_W'(EXT_CREDITS);
         ext_req_o <= 1'b0;
      end
      else
      begin
         credit_q  <= credit_q - CNT_W'(grant_i) + CNT_W'(ext_credit_i);
         ext_req_o <= grant_i;
      end
   end

   // Outbound request payload
   always_ff @(posedge clk_i)
   begin
      if (grant_i)
      begin
         ext_addr_o  <= addr_i;
         ext_wen_o   <= wen_i;
         ext_wdata_o <= wdata_i;
         ext_be_o    <= be_i;
         ext_id_o    <= gnt_idx_i;
      end
   end

endmodule

// File: l2_bank.sv
// Single-port L2 word bank
// Active-low chip select, write enable high for a write, byte-masked
// writes, read data registered one cycle after the access

module l2_bank
#(
   parameter int BANK_ADDR_WIDTH = 8
)
(
   input  logic                       clk_i,
   input  logic                       csn_i,
   input  logic                       wen_i,
   input  logic [BANK_ADDR_WIDTH-1:0] row_i,
   input  fc_l2_pkg::data_t           wdata_i,
   input  fc_l2_pkg::be_t             be_i,
   output fc_l2_pkg::data_t           rdata_o
);

   localparam int ROWS = 2 ** BANK_ADDR_WIDTH;

   fc_l2_pkg::data_t mem_q [ROWS];

   always_ff @(posedge clk_i)
   begin
      if (!csn_i)
      begin
         if (wen_i)
         begin
            // Merge only the enabled bytes
            for (int i = 0; i < fc_l2_pkg::BE_WIDTH; i++)
            begin
               if (be_i[i])
               begin
                  mem_q[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
               end
            end
         end
         else
         begin
            rdata_o <= mem_q[row_i];
         end
      end
   end

endmodule

// File: fc_target_arbiter.sv
// Round-robin arbiter for one interconnect target
// Grants the first requester at or after the pointer in the same cycle;
// the pointer moves past the winner on the next clock edge

module fc_target_arbiter
#(
   parameter  int N_MASTERS = 3,
   localparam int IDX_W     = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1
)
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic [N_MASTERS-1:0] req_i,
   input  logic                 enable_i,
   output logic [N_MASTERS-1:0] gnt_o,
   output logic [IDX_W-1:0]     gnt_idx_o
);

   logic [IDX_W-1:0] ptr_q;

   // ------------------------------------------------------------
   // Grant selection
   // ------------------------------------------------------------
   always_comb
   begin : grant_sel
      int unsigned cand;

      gnt_o     = '0;
      gnt_idx_o = '0;
      // Walk from the far end so the closest requester to ptr_q wins
      for (int k = N_MASTERS - 1; k >= 0; k--)
      begin
         cand = (int'(ptr_q) + k) % N_MASTERS;
         if (enable_i && req_i[cand])
         begin
            gnt_o       = '0;
            gnt_o[cand] = 1'b1;
            gnt_idx_o   = IDX_W'(cand);
         end
      end
   end

   // ------------------------------------------------------------
   // Priority pointer
   // ------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         ptr_q <= '0;
      end
      else if (|gnt_o)
      begin
         if (gnt_idx_o == IDX_W'(N_MASTERS - 1))
         begin
            ptr_q <= '0;
         end
         else
         begin
            ptr_q <= gnt_idx_o + 1'b1;
         end
      end
   end

endmodule

// File: fc_addr_decode.sv
// Decode stage of the interconnect
// Sorts each master request into bank, bridge or out-of-range L2 target
// and holds a master off arbitration while its transaction is outstanding

module fc_addr_decode
#(
   parameter int N_MASTERS       = 3,
   parameter int N_L2_BANKS      = 4,
   parameter int BANK_ADDR_WIDTH = 8
)
(
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic [N_MASTERS-1:0]                 req_i,
   input  fc_l2_pkg::addr_t [N_MASTERS-1:0]     addr_i,
   input  logic [N_MASTERS-1:0]                 rsp_done_i,
   output logic [N_L2_BANKS-1:0][N_MASTERS-1:0] bank_req_o,
   output logic [N_MASTERS-1:0]                 ext_req_o,
   output logic [N_MASTERS-1:0]                 err_req_o,
   input  logic [N_MASTERS-1:0]                 gnt_i
);

   localparam int BANK_SEL_W = $clog2(N_L2_BANKS);
   // Bytes covered by all banks together, as log2
   localparam int CAP_LOG2   = fc_l2_pkg::WORD_OFFSET + BANK_SEL_W + BANK_ADDR_WIDTH;
   localparam fc_l2_pkg::addr_t L2_TAG = fc_l2_pkg::L2_BASE >> fc_l2_pkg::L2_SPAN_LOG2;

   logic [N_MASTERS-1:0]                 busy_q;
   logic [N_MASTERS-1:0]                 eligible;
   logic [N_MASTERS-1:0]                 in_l2;
   logic [N_MASTERS-1:0]                 in_range;
   fc_l2_pkg::addr_t [N_MASTERS-1:0]     l2_off;
   logic [N_MASTERS-1:0][BANK_SEL_W-1:0] bank_sel;

   // Target classification
   always_comb
   begin
      for (int m = 0; m < N_MASTERS; m++)
      begin
         l2_off[m]   = addr_i[m] - fc_l2_pkg::L2_BASE;
         in_l2[m]    = (addr_i[m] >> fc_l2_pkg::L2_SPAN_LOG2) == L2_TAG;
         in_range[m] = (l2_off[m] >> CAP_LOG2) == '0;
         // Word interleave: low word-address bits pick the bank
         bank_sel[m] = addr_i[m][fc_l2_pkg::WORD_OFFSET +: BANK_SEL_W];
      end

      eligible  = req_i & ~busy_q;
      ext_req_o = eligible & ~in_l2;
      err_req_o = eligible & in_l2 & ~in_range;

      for (int b = 0; b < N_L2_BANKS; b++)
      begin
         for (int m = 0; m < N_MASTERS; m++)
         begin
            bank_req_o[b][m] = eligible[m] & in_l2[m] & in_range[m]
                               & (bank_sel[m] == BANK_SEL_W'(b));
         end
      end
   end

   // One outstanding transaction per master
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         busy_q <= '0;
      end
      else
      begin
         busy_q <= (busy_q & ~rsp_done_i) | gnt_i;
      end
   end

endmodule

// File: fc_l2_pkg.sv
// Shared address map, widths and response codes of the FC memory interconnect
// Referenced by scoped names from every module that needs them

package fc_l2_pkg;

   // ------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;
   localparam int BE_WIDTH   = DATA_WIDTH / 8;

   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [DATA_WIDTH-1:0] data_t;
   typedef logic [BE_WIDTH-1:0]   be_t;

   // ------------------------------------------------------------
   // Address map
   // ------------------------------------------------------------
   // L2 window, 64 KiB aligned; the banks fill only its bottom part
   localparam addr_t L2_BASE      = 32'h1C00_0000;
   localparam int    L2_SPAN_LOG2 = 16;

   // Byte offset bits inside a 32-bit word
   localparam int WORD_OFFSET = 2;

   // ------------------------------------------------------------
   // Response codes on r_opc
   // ------------------------------------------------------------
   localparam logic OPC_OK  = 1'b0;
   localparam logic OPC_ERR = 1'b1;

endpackage
